// File: gelu_lut_table.svh
`ifndef GELU_LUT_TABLE_SVH
`define GELU_LUT_TABLE_SVH

// Entry i is 16 * GELU((i - 64) / 16), rounded half away from zero.
localparam fixed_t GELU_LUT [LUT_ENTRIES] = '{
   8'sd0,   8'sd0,  // x = -4.0
   8'sd0,   8'sd0,
   8'sd0,   8'sd0,
   8'sd0,   8'sd0,
   8'sd0,   8'sd0,
   8'sd0,   8'sd0,
   8'sd0,   8'sd0,
   8'sd0,   8'sd0,
   8'sd0,   8'sd0,
   8'sd0,   8'sd0,
   8'sd0,   8'sd0,
   8'sd0,   8'sd0,
   8'sd0,   8'sd0,
   8'sd0,   8'sd0,
   8'sd0,  -8'sd1,
  -8'sd1,  -8'sd1,
  -8'sd1,  -8'sd1,  // x = -2.0
  -8'sd1,  -8'sd1,
  -8'sd1,  -8'sd1,
  -8'sd1,  -8'sd1,
  -8'sd2,  -8'sd2,
  -8'sd2,  -8'sd2,
  -8'sd2,  -8'sd2,
  -8'sd2,  -8'sd2,
  -8'sd3,  -8'sd3,  // x = -1.0
  -8'sd3,  -8'sd3,
  -8'sd3,  -8'sd3,
  -8'sd3,  -8'sd3,
  -8'sd2,  -8'sd2,
  -8'sd2,  -8'sd2,
  -8'sd2,  -8'sd1,
  -8'sd1,   8'sd0,
   8'sd0,   8'sd1,  // x = 0.0
   8'sd1,   8'sd2,
   8'sd2,   8'sd3,
   8'sd4,   8'sd5,
   8'sd6,   8'sd6,
   8'sd7,   8'sd8,
   8'sd9,   8'sd10,
   8'sd11,  8'sd12,
   8'sd13,  8'sd15,  // x = 1.0
   8'sd16,  8'sd17,
   8'sd18,  8'sd19,
   8'sd20,  8'sd21,
   8'sd22,  8'sd24,
   8'sd25,  8'sd26,
   8'sd27,  8'sd28,
   8'sd29,  8'sd30,
   8'sd31,  8'sd32,  // x = 2.0
   8'sd33,  8'sd34,
   8'sd36,  8'sd37,
   8'sd38,  8'sd39,
   8'sd40,  8'sd41,
   8'sd42,  8'sd43,
   8'sd44,  8'sd45,
   8'sd46,  8'sd47,
   8'sd48,  8'sd49,  // x = 3.0
   8'sd50,  8'sd51,
   8'sd52,  8'sd53,
   8'sd54,  8'sd55,
   8'sd56,  8'sd57,
   8'sd58,  8'sd59,
   8'sd60,  8'sd61,
   8'sd62,  8'sd63
};

`endif

// File: gelu_pkg.sv
`default_nettype none

package gelu_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Fixed-point format
  // ~~~~~~~~~~~~~~~~~~~~

  localparam int DATA_WIDTH = 8;
  localparam int FRAC_BITS  = 4;

  typedef logic signed [DATA_WIDTH-1:0] fixed_t;  // One lane, Q3.4.

  // ~~~~~~~~~~~~~~~~~~~~
  // Table range
  // ~~~~~~~~~~~~~~~~~~~~

  // The table covers x in [-RANGE_LIMIT, RANGE_LIMIT).
  localparam int RANGE_LIMIT  = 4;
  localparam int TABLE_OFFSET = RANGE_LIMIT << FRAC_BITS;  // 64 codes on each side of zero.
  localparam int LUT_ENTRIES  = 128;
  localparam int INDEX_WIDTH  = $clog2(LUT_ENTRIES);

  localparam fixed_t TABLE_MIN = fixed_t'(-TABLE_OFFSET);
  localparam fixed_t TABLE_MAX = fixed_t'(TABLE_OFFSET - 1);

  typedef logic [INDEX_WIDTH-1:0] lut_index_t;

  // Where a lane falls relative to the table range.
  typedef enum logic [1:0] {
    class_low,
    class_table,
    class_high
  } range_class_t;

endpackage

`default_nettype wire

// File: gelu_op_if.sv
`default_nettype none

// One decoded beat between two register stages of the GELU pipeline.
interface gelu_op_if #(
  parameter int LANES = 4
);
  import gelu_pkg::*;

  logic                   valid;
  logic                   ready;
  range_class_t           cls [LANES];
  lut_index_t [LANES-1:0] index;
  fixed_t     [LANES-1:0] value;  // Raw input, or the table value once looked up.

  modport source (
    output valid,
    output cls,
    output index,
    output value,
    input  ready
  );

  modport sink (
    input  valid,
    input  cls,
    input  index,
    input  value,
    output ready
  );

endinterface

`default_nettype wire

// File: gelu_input_fifo.sv
`default_nettype none

module gelu_input_fifo #(
  parameter int LANES      = 4,
  parameter int FIFO_DEPTH = 16
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         in_valid,
  output logic                         in_ready,
  input  gelu_pkg::fixed_t [LANES-1:0] in_data,
  output logic                         out_valid,
  input  logic                         out_ready,
  output gelu_pkg::fixed_t [LANES-1:0] out_data
);
  import gelu_pkg::*;

  localparam int PTR_WIDTH   = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

  fixed_t [LANES-1:0]   mem [FIFO_DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [COUNT_WIDTH-1:0] count;  // Beats held, output register included.
  logic                 push;
  logic                 pop;
  logic                 load;
  logic                 mem_empty;

  function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
    return (ptr == PTR_WIDTH'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~
  // Handshake
  // ~~~~~~~~~~~~~~~~~~~~

  assign in_ready  = (count != COUNT_WIDTH'(FIFO_DEPTH));
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;
  assign mem_empty = (count == COUNT_WIDTH'(out_valid));
  // Refill the output register whenever it is free or being emptied.
  assign load      = !mem_empty && (!out_valid || out_ready);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
    if (load) begin
      out_data <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      out_valid <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (load) begin
        rd_ptr    <= next_ptr(rd_ptr);
        out_valid <= 1'b1;
      end else if (pop) begin
        out_valid <= 1'b0;
      end
      count <= count + COUNT_WIDTH'(push) - COUNT_WIDTH'(pop);
    end
  end

  a_count_in_range: assert property (
    @(posedge clk) disable iff (reset) count <= COUNT_WIDTH'(FIFO_DEPTH)
  );

  a_out_hold: assert property (
    @(posedge clk) disable iff (reset)
      out_valid && !out_ready |=> out_valid && $stable(out_data)
  );

endmodule

`default_nettype wire

// File: gelu_operand_decode.sv
`default_nettype none

module gelu_operand_decode #(
  parameter int LANES = 4
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         in_valid,
  output logic                         in_ready,
  input  gelu_pkg::fixed_t [LANES-1:0] in_data,
  gelu_op_if.source                    dec
);
  import gelu_pkg::*;

  range_class_t           lane_cls [LANES];
  lut_index_t [LANES-1:0] lane_index;
  logic                   accept;

  assign in_ready = !dec.valid || dec.ready;  // Empty, or draining this cycle.
  assign accept   = in_valid && in_ready;

  // ~~~~~~~~~~~~~~~~~~~~
  // Lane classification
  // ~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    for (int lane = 0; lane < LANES; lane++) begin
      if (in_data[lane] < TABLE_MIN) begin
        lane_cls[lane] = class_low;
      end else if (in_data[lane] > TABLE_MAX) begin
        lane_cls[lane] = class_high;
      end else begin
        lane_cls[lane] = class_table;
      end
      // Shift the code so that x = -4 lands on entry 0.
      lane_index[lane] = lut_index_t'(in_data[lane] - TABLE_MIN);
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Stage register
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (reset) begin
      dec.valid <= 1'b0;
    end else if (accept) begin
      dec.valid <= 1'b1;
    end else if (dec.ready) begin
      dec.valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      dec.cls   <= lane_cls;
      dec.index <= lane_index;
      dec.value <= in_data;
    end
  end

endmodule

`default_nettype wire

// File: gelu_lut_lookup.sv
`default_nettype none

module gelu_lut_lookup #(
  parameter int LANES = 4
) (
  input  logic    clk,
  input  logic    reset,
  gelu_op_if.sink dec,
  gelu_op_if.source exe
);
  import gelu_pkg::*;

  `include "gelu_lut_table.svh"

  logic accept;

  assign dec.ready = !exe.valid || exe.ready;
  assign accept    = dec.valid && dec.ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      exe.valid <= 1'b0;
    end else if (accept) begin
      exe.valid <= 1'b1;
    end else if (exe.ready) begin
      exe.valid <= 1'b0;
    end
  end

  // One table read per lane. Lanes outside the table keep their raw code.
  always_ff @(posedge clk) begin
    if (accept) begin
      exe.cls   <= dec.cls;
      exe.index <= dec.index;
      for (int lane = 0; lane < LANES; lane++) begin
        if (dec.cls[lane] == class_table) begin
          exe.value[lane] <= GELU_LUT[dec.index[lane]];
        end else begin
          exe.value[lane] <= dec.value[lane];
        end
      end
    end
  end

  // The decode stage must hand over a clean index with every beat.
  a_index_known: assert property (
    @(posedge clk) disable iff (reset) dec.valid |-> !$isunknown(dec.index)
  );

endmodule

`default_nettype wire

// File: gelu_result_pack.sv
`default_nettype none

module gelu_result_pack #(
  parameter int LANES = 4
) (
  input  logic                         clk,
  input  logic                         reset,
  gelu_op_if.sink                      exe,
  output logic                         out_valid,
  input  logic                         out_ready,
  output gelu_pkg::fixed_t [LANES-1:0] out_data
);
  import gelu_pkg::*;

  fixed_t [LANES-1:0] lane_result;
  logic               accept;

  assign exe.ready = !out_valid || out_ready;
  assign accept    = exe.valid && exe.ready;

  // ~~~~~~~~~~~~~~~~~~~~
  // Final selection
  // ~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    for (int lane = 0; lane < LANES; lane++) begin
      case (exe.cls[lane])
        class_low: begin
          lane_result[lane] = '0;  // GELU vanishes well below -4.
        end
        class_table, class_high: begin
          lane_result[lane] = exe.value[lane];  // Table value, or the raw code above 4.
        end
        default: begin
          lane_result[lane] = '0;
        end
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Output register
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (accept) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_data <= lane_result;
    end
  end

  property p_out_hold;
    @(posedge clk) disable iff (reset)
      out_valid && !out_ready |=> out_valid && $stable(out_data);
  endproperty

  a_out_hold: assert property (p_out_hold);

endmodule

`default_nettype wire

// File: gelu_stream.sv
`default_nettype none

module gelu_stream #(
  parameter int LANES      = 4,
  parameter int FIFO_DEPTH = 16
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         in_valid,
  output logic                         in_ready,
  input  gelu_pkg::fixed_t [LANES-1:0] in_data,
  output logic                         out_valid,
  input  logic                         out_ready,
  output gelu_pkg::fixed_t [LANES-1:0] out_data
);
  import gelu_pkg::*;

  logic               fifo_valid;
  logic               fifo_ready;
  fixed_t [LANES-1:0] fifo_data;

  gelu_op_if #(.LANES(LANES)) dec_if ();
  gelu_op_if #(.LANES(LANES)) exe_if ();

  // ~~~~~~~~~~~~~~~~~~~~
  // Row buffer
  // ~~~~~~~~~~~~~~~~~~~~

  gelu_input_fifo #(
    .LANES     (LANES),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_fifo (
    .clk      (clk),
    .reset    (reset),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_data  (in_data),
    .out_valid(fifo_valid),
    .out_ready(fifo_ready),
    .out_data (fifo_data)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // Decode, execute, result
  // ~~~~~~~~~~~~~~~~~~~~

  gelu_operand_decode #(.LANES(LANES)) u_decode (
    .clk     (clk),
    .reset   (reset),
    .in_valid(fifo_valid),
    .in_ready(fifo_ready),
    .in_data (fifo_data),
    .dec     (dec_if.source)
  );

  gelu_lut_lookup #(.LANES(LANES)) u_lookup (
    .clk  (clk),
    .reset(reset),
    .dec  (dec_if.sink),
    .exe  (exe_if.source)
  );

  gelu_result_pack #(.LANES(LANES)) u_result (
    .clk      (clk),
    .reset    (reset),
    .exe      (exe_if.sink),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_data (out_data)
  );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
  parameter real PERIOD = 8.0
) (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2.0) clk = ~clk;
  end

endmodule

`default_nettype wire

// File: tb_gelu_stream.sv
`default_nettype none

module tb_gelu_stream;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int LANES      = 4;
  localparam int FIFO_DEPTH = 16;
  localparam int BEAT_W     = LANES * 8;

  logic              clk;
  logic              reset;
  logic              in_valid;
  logic              in_ready;
  logic [BEAT_W-1:0] in_data;
  logic              out_valid;
  logic              out_ready;
  logic [BEAT_W-1:0] out_data;

  string             case_name [$];
  logic [BEAT_W-1:0] case_in [$];
  logic [BEAT_W-1:0] case_exp [$];
  string             exp_name_q [$];  // Expected beats in the order they must leave.
  logic [BEAT_W-1:0] exp_data_q [$];
  logic [1:0]        ready_mode;      // 0 high, 1 random, 2 low.
  int                cycle_count;
  int                cycle_limit;

  tb_clock_gen clock (.clk(clk));

  gelu_stream #(.LANES(LANES), .FIFO_DEPTH(FIFO_DEPTH)) uut (
    .clk      (clk),
    .reset    (reset),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_data  (in_data),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_data (out_data)
  );

  task automatic report_failure(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_value(input string test_name, input logic [BEAT_W-1:0] expected,
                             input logic [BEAT_W-1:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s: expected %h, actual %h", test_name, expected, actual);
      report_failure("A checked value did not match.");
    end
  endtask

  task automatic load_cases();
    int         fd;
    int         fields;
    string      line;
    string      name;
    logic [7:0] code [2*LANES];
    fd = $fopen("gelu_stream_cases.txt", "r");
    if (fd == 0) begin
      report_failure("Could not open the cases file gelu_stream_cases.txt.");
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") continue;  // Blank or comment line.
      fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h", name, code[0], code[1], code[2],
                       code[3], code[4], code[5], code[6], code[7]);
      if (fields != 9) begin
        report_failure({"Malformed line in the cases file: ", line});
      end
      case_name.push_back(name);
      case_in.push_back({code[3], code[2], code[1], code[0]});
      case_exp.push_back({code[7], code[6], code[5], code[4]});
    end
    $fclose(fd);
  endtask

  // Drives one beat for a single edge and queues its expected result if it was taken.
  task automatic offer_beat(input int idx, input string tag, output logic taken);
    in_valid <= 1'b1;
    in_data  <= case_in[idx];
    @(posedge clk);
    taken = in_ready;
    if (taken) begin
      exp_name_q.push_back({tag, case_name[idx]});
      exp_data_q.push_back(case_exp[idx]);
    end
  endtask

  task automatic send_beat(input int idx, input string tag);
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      offer_beat(idx, tag, taken);
    end
  endtask

  task automatic drain();
    in_valid <= 1'b0;
    while (exp_data_q.size() != 0) @(posedge clk);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Output side
  // ~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk) begin
    case (ready_mode)
      2'd1:    out_ready <= 1'($urandom_range(1, 0));
      2'd2:    out_ready <= 1'b0;
      default: out_ready <= 1'b1;
    endcase
  end

  always @(posedge clk) begin
    if (!reset && out_valid && out_ready) begin
      if (exp_data_q.size() == 0) begin
        report_failure("An output beat appeared with no input beat waiting for it.");
      end else begin
        check_value(exp_name_q.pop_front(), exp_data_q.pop_front(), out_data);
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      report_failure("Timeout: the run did not finish within its cycle limit.");
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  // ~~~~~~~~~~~~~~~~~~~~

  initial begin
    int   latency;
    int   accepted;
    logic taken;
    reset       = 1'b1;
    in_valid    = 1'b0;
    in_data     = '0;
    out_ready   = 1'b1;
    ready_mode  = 2'd0;
    cycle_count = 0;
    void'($urandom(51));
    load_cases();
    cycle_limit = 20 * (2 * case_in.size() + FIFO_DEPTH + 5) + 200;
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    repeat (4) begin
      @(posedge clk);
      check_value("reset_idle", BEAT_W'(2'b01), BEAT_W'({out_valid, in_ready}));
    end

    send_beat(0, "latency/");
    in_valid <= 1'b0;  // A single beat travels through an otherwise empty pipeline.
    latency = 0;
    do begin
      @(posedge clk);
      latency++;
    end while (!out_valid);
    check_value("latency", BEAT_W'(4), BEAT_W'(latency - 1));  // First seen one edge late.
    drain();

    foreach (case_in[i]) send_beat(i, "full/");
    drain();

    ready_mode <= 2'd1;
    foreach (case_in[i]) send_beat(i, "random/");
    drain();

    // The FIFO and the three stage registers fill before in_ready drops.
    ready_mode <= 2'd2;
    @(posedge clk);
    accepted = 0;
    taken    = 1'b1;
    while (taken) begin
      offer_beat(accepted % case_in.size(), "fill/", taken);
      if (taken) accepted++;
    end
    check_value("fill_count", BEAT_W'(FIFO_DEPTH + 3), BEAT_W'(accepted));
    repeat (4) begin
      @(posedge clk);
      check_value("fill_hold", BEAT_W'(0), BEAT_W'(in_ready));
    end
    ready_mode <= 2'd0;
    send_beat(accepted % case_in.size(), "fill/");
    drain();

    repeat (10) @(posedge clk);  // Catches any duplicated beat.
    if (exp_data_q.size() == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      report_failure("Some input beats never came out of the pipeline.");
    end
  end

endmodule

`default_nettype wire

// File: gelu_stream.f
+incdir+.
gelu_pkg.sv
gelu_op_if.sv
gelu_input_fifo.sv
gelu_operand_decode.sv
gelu_lut_lookup.sv
gelu_result_pack.sv
gelu_stream.sv
tb_clock_gen.sv
tb_gelu_stream.sv

// File: gelu_stream_cases.txt
# name  in0 in1 in2 in3  exp0 exp1 exp2 exp3  (8-bit hex codes with 4 fraction bits, lane 0 first)
# Codes -64..63 follow the GELU table, codes below -64 give 0, codes of 64 and above pass through.
zero_one     00 10 08 f0  00 0d 06 fd
table_edges  c0 3f ff fe  00 3f 00 ff
small_pos    01 02 03 04  01 01 02 02
mid_pos      0a 0c 14 18  07 09 12 16
large_pos    19 20 28 30  18 1f 28 30
neg_mid      fc fa f8 f4  fe fe fe fd
neg_far      ec e8 e0 dc  fe fe ff 00
below_range  bf 80 9c b0  00 00 00 00
above_range  40 7f 64 50  40 7f 64 50
mixed_lanes  bf 40 10 c0  00 40 0d 00
mixed_flip   40 bf 00 3f  40 00 00 3f
pos_steps    05 06 07 0e  03 04 05 0b
pos_steps2   0f 11 1c 22  0c 0f 1b 21
pos_high     24 38 3f 40  24 38 3f 40
neg_steps    f6 f2 e4 d0  fd fd ff 00
neg_edge     c0 bf c1 ff  00 00 00 00
